/* cpu_word_pkg.sv */
package cpu_word_pkg;

    // datapath word width
    localparam int word_w = 32;

    // low bits of src2 used as a shift amount
    localparam int shamt_w = 5;

    // divider iteration counter, one step per quotient bit
    localparam int step_w = $clog2(word_w);

    // one register-file word
    typedef logic [word_w-1:0] word_t;

    // shift amount for sll, srl and sra
    typedef logic [shamt_w-1:0] shamt_t;

    // index of the current restoring step
    typedef logic [step_w-1:0] step_t;

endpackage

/* alu_op_pkg.sv */
package alu_op_pkg;

    // operation code as issued by decode
    typedef enum logic [4:0] {
        op_add,
        op_sub,
        op_slt,
        op_sltu,
        op_nor,
        op_and,
        op_or,
        op_xor,
        op_sll,
        op_srl,
        op_sra,
        op_div,
        op_divu,
        op_mod,
        op_modu,
        op_lui,
        op_pcadd4
    } alu_op_e;

    // constant addend for the link address
    localparam cpu_word_pkg::word_t pc_step = 32'd4;

    // bit positions in the one-hot result select
    localparam int sel_sum  = 0;
    localparam int sel_slt  = 1;
    localparam int sel_sltu = 2;
    localparam int sel_lsh  = 3;
    localparam int sel_quo  = 4;
    localparam int sel_rem  = 5;
    localparam int sel_src2 = 6;
    localparam int sel_w    = 7;

    // one-hot result select
    typedef logic [sel_w-1:0] sel_t;

    // request: operation plus both operands
    typedef struct packed {
        alu_op_e             op;
        cpu_word_pkg::word_t src1;
        cpu_word_pkg::word_t src2;
    } alu_req_t;

    // response: result word and adder carry-out
    typedef struct packed {
        cpu_word_pkg::word_t result;
        logic                carry;
    } alu_resp_t;

endpackage

/* alu_adder.sv */
`timescale 1ns/1ps

module alu_adder (
    input  cpu_word_pkg::word_t src1,
    input  cpu_word_pkg::word_t src2,
    input  logic                subtract,
    input  logic                add_step,
    output cpu_word_pkg::word_t sum,
    output cpu_word_pkg::word_t slt,
    output cpu_word_pkg::word_t sltu,
    output logic                carry
);
    import cpu_word_pkg::*;
    import alu_op_pkg::*;

    // second adder input after mode selection
    word_t b_op;
    // signed compare bit
    logic  lt_bit;
    // sign bits of both operands and of the difference
    logic  s1_neg;
    logic  s2_neg;
    logic  sum_neg;

    // constant four wins over subtract
    // sub, slt and sltu use ~src2 with carry-in set
    always_comb begin
        if (add_step) begin
            b_op = pc_step;
        end else if (subtract) begin
            b_op = ~src2;
        end else begin
            b_op = src2;
        end
    end

    // one 33-bit add gives sum and carry-out together
    // carry-in is the +1 of two's complement
    assign {carry, sum} = {1'b0, src1} + {1'b0, b_op} + {{word_w{1'b0}}, subtract};

    assign s1_neg  = src1[word_w-1];
    assign s2_neg  = src2[word_w-1];
    assign sum_neg = sum[word_w-1];

    // src1 negative and src2 not -> less
    // same signs -> the difference sign decides, no overflow possible
    assign lt_bit = (s1_neg & ~s2_neg) | (~(s1_neg ^ s2_neg) & sum_neg);

    // compare results in bit zero
    assign slt = {{(word_w-1){1'b0}}, lt_bit};

    // no carry out of a - b means a borrow, so a < b unsigned
    assign sltu = {{(word_w-1){1'b0}}, ~carry};

endmodule

/* alu_logic_shift.sv */
`timescale 1ns/1ps

module alu_logic_shift (
    input  cpu_word_pkg::word_t src1,
    input  cpu_word_pkg::word_t src2,
    input  alu_op_pkg::alu_op_e op,
    output cpu_word_pkg::word_t result
);
    import cpu_word_pkg::*;
    import alu_op_pkg::*;

    // shift amount, upper bits of src2 ignored
    shamt_t shamt;

    assign shamt = src2[shamt_w-1:0];

    // anything outside this group reads as zero
    // and the top level masks it off anyway
    always_comb begin
        case (op)
            op_nor:  result = ~(src1 | src2);
            op_and:  result = src1 & src2;
            op_or:   result = src1 | src2;
            op_xor:  result = src1 ^ src2;
            // zero fill from the right
            op_sll:  result = src1 << shamt;
            // zero fill from the left
            op_srl:  result = src1 >> shamt;
            // sign of src1 replicated into the vacated bits
            op_sra:  result = $signed(src1) >>> shamt;
            default: result = '0;
        endcase
    end

endmodule

/* div_unit.sv */
`timescale 1ns/1ps

module div_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic                is_signed,
    input  cpu_word_pkg::word_t dividend,
    input  cpu_word_pkg::word_t divisor,
    input  logic                ack,
    output logic                done,
    output cpu_word_pkg::word_t quotient,
    output cpu_word_pkg::word_t remainder
);
    import cpu_word_pkg::*;

    // idle -> run (word_w steps) -> fix (signs) -> hold (until ack)
    typedef enum logic [1:0] {
        idle,
        run,
        fix,
        hold
    } div_state_e;

    div_state_e state;
    step_t      step;

    // quo_r starts as the dividend magnitude and shifts out into the remainder
    word_t quo_r;
    word_t rem_r;
    // divisor magnitude
    word_t dvs_r;
    // result signs captured at start
    logic  q_neg;
    logic  r_neg;

    logic  dend_neg;
    logic  dsor_neg;
    word_t dend_mag;
    word_t dsor_mag;
    logic  div_zero;

    // partial remainder one bit wider than a word
    logic [word_w:0] partial;
    logic [word_w:0] trial;

    // operand signs only count for signed ops
    assign dend_neg = is_signed & dividend[word_w-1];
    assign dsor_neg = is_signed & divisor[word_w-1];
    assign dend_mag = dend_neg ? -dividend : dividend;
    assign dsor_mag = dsor_neg ? -divisor : divisor;
    assign div_zero = (divisor == '0);

    // shift next dividend bit into the remainder, then try the subtract
    assign partial = {rem_r, quo_r[word_w-1]};
    assign trial   = partial - {1'b0, dvs_r};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
            step  <= '0;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        // zero divisor needs no iteration
                        state <= div_zero ? hold : run;
                        step  <= '0;
                    end
                end
                run: begin
                    step <= step + 1'b1;
                    if (step == step_t'(word_w - 1)) begin
                        state <= fix;
                    end
                end
                fix: state <= hold;
                hold: begin
                    if (ack) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            idle: begin
                if (start) begin
                    if (div_zero) begin
                        // defined result: all ones, remainder is the raw dividend
                        quo_r <= '1;
                        rem_r <= dividend;
                    end else begin
                        quo_r <= dend_mag;
                        rem_r <= '0;
                    end
                    dvs_r <= dsor_mag;
                    q_neg <= dend_neg ^ dsor_neg;
                    r_neg <= dend_neg;
                end
            end
            run: begin
                // borrow -> restore, quotient bit 0
                if (trial[word_w]) begin
                    rem_r <= partial[word_w-1:0];
                end else begin
                    rem_r <= trial[word_w-1:0];
                end
                quo_r <= {quo_r[word_w-2:0], ~trial[word_w]};
            end
            fix: begin
                // most negative / -1 stays as is since q_neg is clear
                if (q_neg) begin
                    quo_r <= -quo_r;
                end
                if (r_neg) begin
                    rem_r <= -rem_r;
                end
            end
            default: begin
            end
        endcase
    end

    assign done      = (state == hold);
    assign quotient  = quo_r;
    assign remainder = rem_r;

endmodule

/* alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic                  clk,
    input  logic                  rst_n,
    input  alu_op_pkg::alu_req_t  req,
    input  logic                  req_valid,
    output logic                  req_ready,
    output alu_op_pkg::alu_resp_t resp,
    output logic                  resp_valid,
    input  logic                  resp_ready
);
    import cpu_word_pkg::*;
    import alu_op_pkg::*;

    // select decoded from the incoming op
    sel_t op_sel;
    // quo or rem select, kept for the divide in flight
    sel_t div_sel;
    // select that actually drives the output register
    sel_t fin_sel;

    logic subtract;
    logic add_step;
    logic is_div;
    logic div_signed;

    word_t sum;
    word_t slt;
    word_t sltu;
    logic  add_carry;
    word_t lsh_res;
    word_t quotient;
    word_t remainder;
    logic  div_done;

    // handshake state
    logic      div_busy;
    logic      out_free;
    logic      accept;
    logic      div_ack;
    logic      load;
    alu_resp_t next_resp;

    // adder modes
    assign subtract = (req.op == op_sub) | (req.op == op_slt) | (req.op == op_sltu);
    assign add_step = (req.op == op_pcadd4);

    // one-hot decode
    assign op_sel[sel_sum]  = (req.op == op_add) | (req.op == op_sub) | add_step;
    assign op_sel[sel_slt]  = (req.op == op_slt);
    assign op_sel[sel_sltu] = (req.op == op_sltu);
    assign op_sel[sel_lsh]  = (req.op == op_nor) | (req.op == op_and) | (req.op == op_or) |
                              (req.op == op_xor) | (req.op == op_sll) | (req.op == op_srl) |
                              (req.op == op_sra);
    assign op_sel[sel_quo]  = (req.op == op_div) | (req.op == op_divu);
    assign op_sel[sel_rem]  = (req.op == op_mod) | (req.op == op_modu);
    assign op_sel[sel_src2] = (req.op == op_lui);

    assign is_div     = op_sel[sel_quo] | op_sel[sel_rem];
    assign div_signed = (req.op == op_div) | (req.op == op_mod);

    alu_adder i_adder (
        .src1     (req.src1),
        .src2     (req.src2),
        .subtract (subtract),
        .add_step (add_step),
        .sum      (sum),
        .slt      (slt),
        .sltu     (sltu),
        .carry    (add_carry)
    );

    alu_logic_shift i_logic_shift (
        .src1   (req.src1),
        .src2   (req.src2),
        .op     (req.op),
        .result (lsh_res)
    );

    div_unit i_div (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (accept & is_div),
        .is_signed (div_signed),
        .dividend  (req.src1),
        .divisor   (req.src2),
        .ack       (div_ack),
        .done      (div_done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    // output register empty or draining this cycle
    assign out_free  = ~resp_valid | resp_ready;
    assign req_ready = out_free & ~div_busy;
    assign accept    = req_valid & req_ready;

    // divider result leaves only when there is room for it
    assign div_ack = div_done & out_free;
    assign load    = (accept & ~is_div) | div_ack;

    // divide completion overrides the request decode
    assign fin_sel = div_ack ? div_sel : op_sel;

    // AND-OR result select
    assign next_resp.result = ({word_w{fin_sel[sel_sum]}}  & sum)       |
                              ({word_w{fin_sel[sel_slt]}}  & slt)       |
                              ({word_w{fin_sel[sel_sltu]}} & sltu)      |
                              ({word_w{fin_sel[sel_lsh]}}  & lsh_res)   |
                              ({word_w{fin_sel[sel_quo]}}  & quotient)  |
                              ({word_w{fin_sel[sel_rem]}}  & remainder) |
                              ({word_w{fin_sel[sel_src2]}} & req.src2);

    // carry only for ops that went through the adder
    assign next_resp.carry = add_carry &
                             (fin_sel[sel_sum] | fin_sel[sel_slt] | fin_sel[sel_sltu]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
            div_busy   <= 1'b0;
        end else begin
            if (load) begin
                resp_valid <= 1'b1;
            end else if (resp_ready) begin
                resp_valid <= 1'b0;
            end
            // blocks new requests from divide accept until its result is taken
            if (accept & is_div) begin
                div_busy <= 1'b1;
            end else if (div_ack) begin
                div_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            resp <= next_resp;
        end
        if (accept & is_div) begin
            div_sel <= op_sel;
        end
    end

endmodule

/* tb_alu_chk.sv */
`timescale 1ns/1ps

module tb_alu_chk (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  req_ready,
    input alu_op_pkg::alu_resp_t resp,
    input logic                  resp_valid,
    input logic                  resp_ready
);

    // output register empty right out of reset
    first_cycle_empty: assert property (@(posedge clk) $rose(rst_n) |-> !resp_valid)
        else $error("resp_valid high in the first cycle after reset");

    // stalled response held unchanged
    stalled_resp_stable: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |=> $stable(resp))
        else $error("resp changed while stalled");

    // valid not dropped without a transfer
    stalled_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |=> resp_valid)
        else $error("resp_valid dropped while stalled");

    // no accept while the output is blocked
    stalled_no_accept: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |-> !req_ready)
        else $error("req_ready high while the response is stalled");

endmodule

bind alu tb_alu_chk i_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_ready  (req_ready),
    .resp       (resp),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready)
);

/* tb_alu.sv */
`timescale 1ns/1ps

module tb_alu;
    import cpu_word_pkg::*;
    import alu_op_pkg::*;

    localparam int seed_init   = 94;
    localparam int num_slots   = 400;
    // cycles allowed for one accept, for the final drain, and to watch for extras
    localparam int accept_wait = 200;
    localparam int drain_wait  = 1000;
    localparam int quiet_wait  = 20;

    logic      clk;
    logic      rst_n;
    alu_req_t  req;
    logic      req_valid;
    logic      req_ready;
    alu_resp_t resp;
    logic      resp_valid;
    logic      resp_ready;

    integer    seed;
    alu_resp_t exp_q[$];
    alu_resp_t exp_head;

    alu i_alu (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready)
    );

    always #5 clk = ~clk;

    task automatic report_fail(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            report_fail("response value mismatch");
        end
    endtask

    // expected response straight from the operation rules
    function automatic alu_resp_t model(input alu_op_e op, input word_t a, input word_t b);
        alu_resp_t r;
        logic signed [word_w-1:0] sa;
        logic signed [word_w-1:0] sb;
        logic ovf;
        sa = a;
        sb = b;
        // most negative over minus one
        ovf = (a == 32'h8000_0000) && (b == '1);
        r.result = '0;
        r.carry  = 1'b0;
        case (op)
            op_add:    {r.carry, r.result} = {1'b0, a} + {1'b0, b};
            op_sub:    r.result = a - b;
            op_slt:    r.result = word_t'(sa < sb);
            op_sltu:   r.result = word_t'(a < b);
            op_pcadd4: {r.carry, r.result} = {1'b0, a} + 33'd4;
            op_nor:    r.result = ~(a | b);
            op_and:    r.result = a & b;
            op_or:     r.result = a | b;
            op_xor:    r.result = a ^ b;
            op_sll:    r.result = a << b[4:0];
            op_srl:    r.result = a >> b[4:0];
            op_sra:    r.result = $unsigned(sa >>> b[4:0]);
            op_lui:    r.result = b;
            op_divu:   r.result = (b == '0) ? '1 : a / b;
            op_modu:   r.result = (b == '0) ? a : a % b;
            op_div:    r.result = (b == '0) ? '1 : (ovf ? a : $unsigned(sa / sb));
            op_mod:    r.result = (b == '0) ? a : (ovf ? '0 : $unsigned(sa % sb));
            default:   r.result = '0;
        endcase
        // subtract path carries out when there is no borrow
        if (op == op_sub || op == op_slt || op == op_sltu) begin
            r.carry = (a >= b);
        end
        return r;
    endfunction

    // corner values mixed into random words
    function automatic word_t pick_word();
        int kind;
        kind = $unsigned($random(seed)) % 8;
        case (kind)
            0: return '0;
            1: return '1;
            2: return 32'h8000_0000;
            3: return $unsigned($random(seed)) % 16;
            default: return $random(seed);
        endcase
    endfunction

    // one request, held until the DUT takes it
    task automatic issue_request();
        alu_req_t r;
        int bias;
        int waited;
        r.op   = alu_op_e'($unsigned($random(seed)) % 17);
        r.src1 = pick_word();
        r.src2 = pick_word();
        bias   = $unsigned($random(seed)) % 4;
        // compares lean on equal operands and opposite signs
        if ((r.op == op_slt || r.op == op_sltu) && bias == 0) begin
            r.src2 = r.src1;
        end else if ((r.op == op_slt || r.op == op_sltu) && bias == 1) begin
            r.src2[word_w-1] = ~r.src1[word_w-1];
        end
        if ((r.op == op_div || r.op == op_mod) && bias == 0) begin
            r.src1 = 32'h8000_0000;
            r.src2 = '1;
        end
        exp_q.push_back(model(r.op, r.src1, r.src2));
        req       = r;
        req_valid = 1'b1;
        waited    = 0;
        @(posedge clk);
        while (!req_ready) begin
            waited++;
            if (waited > accept_wait) begin
                report_fail("timeout: req_ready never came back high");
            end
            @(negedge clk);
            resp_ready = ($unsigned($random(seed)) % 4) != 0;
            @(posedge clk);
        end
    endtask

    // every handshake pops the oldest expected response
    always @(posedge clk) begin
        if (rst_n && resp_valid && resp_ready) begin
            if (exp_q.size() == 0) begin
                report_fail("a response arrived with no request outstanding");
            end else begin
                exp_head = exp_q.pop_front();
                check_value("resp.result", resp.result, exp_head.result);
                check_value("resp.carry", word_t'(resp.carry), word_t'(exp_head.carry));
            end
        end
    end

    initial begin
        int waited;
        clk        = 1'b0;
        rst_n      = 1'b0;
        req        = '0;
        req_valid  = 1'b0;
        resp_ready = 1'b0;
        seed       = seed_init;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int n = 0; n < num_slots; n++) begin
            @(negedge clk);
            // stall the response side about one cycle in four
            resp_ready = ($unsigned($random(seed)) % 4) != 0;
            if ($unsigned($random(seed)) % 8 == 0) begin
                req_valid = 1'b0;
            end else begin
                issue_request();
            end
        end

        @(negedge clk);
        req_valid = 1'b0;
        waited    = 0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > drain_wait) begin
                report_fail("timeout: outstanding responses never arrived");
            end
            @(negedge clk);
            resp_ready = ($unsigned($random(seed)) % 4) != 0;
        end
        // an extra response would show up here
        repeat (quiet_wait) begin
            @(negedge clk);
            resp_ready = 1'b1;
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* tb.f */
cpu_word_pkg.sv
alu_op_pkg.sv
alu_adder.sv
alu_logic_shift.sv
div_unit.sv
alu.sv
tb_alu_chk.sv
tb_alu.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the ALU testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_alu -f tb.f -o tb_alu

# exit status of the simulation is the pass or fail result
./obj_dir/tb_alu
